/* Makefile */
TOOL     ?= verilator
TOP      ?= exec_cluster_tb
FILELIST ?= filelist.f
FLAGS    ?= --binary --timing --assert -Wno-fatal
BUILD    ?= obj_dir
LOG      ?= sim.log

SIM     := $(BUILD)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Testbench passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* filelist.f */
hw/exec_pkg.sv
hw/spill_cell_flush.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/result_arbiter.sv
hw/exec_cluster_top.sv
verification/exec_cluster_tb.sv

/* hw/alu_unit.sv */
// ----------------------------------------
// Single-cycle integer ALU execution unit
// Result registered in a spill cell, one cycle issue to output
// Unknown codes flag an illegal-instruction exception
// ----------------------------------------

module alu_unit (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // Issue port
  input  logic                             valid_i,
  output logic                             ready_o,
  input  logic [exec_pkg::EU_CTL_LEN-1:0]  ctl_i,
  input  exec_pkg::rob_idx_t               rob_idx_i,
  input  logic [exec_pkg::XLEN-1:0]        rs1_i,
  input  logic [exec_pkg::XLEN-1:0]        rs2_i,
  // Result port towards the arbiter
  output logic                             valid_o,
  input  logic                             ready_i,
  output exec_pkg::cdb_data_t              data_o
);

  import exec_pkg::*;

  logic [XLEN-1:0] res;
  logic            illegal;
  logic [4:0]      shamt;
  cdb_data_t       res_data;

  // Only the low 5 bits count for RV32 shifts
  assign shamt = rs2_i[4:0];

  // ---------------------------------------
  // Operation decode
  // ---------------------------------------
  always_comb begin
    res     = '0;
    illegal = 1'b0;
    case (ctl_i)
      ALU_ADD:  res = rs1_i + rs2_i;
      ALU_SUB:  res = rs1_i - rs2_i;
      ALU_AND:  res = rs1_i & rs2_i;
      ALU_OR:   res = rs1_i | rs2_i;
      ALU_XOR:  res = rs1_i ^ rs2_i;
      ALU_SLL:  res = rs1_i << shamt;
      ALU_SRL:  res = rs1_i >> shamt;
      // Arithmetic shift keeps the sign bit
      ALU_SRA:  res = $unsigned($signed(rs1_i) >>> shamt);
      // Compare results are 0 or 1
      ALU_SLT:  res = {{(XLEN-1){1'b0}}, $signed(rs1_i) < $signed(rs2_i)};
      ALU_SLTU: res = {{(XLEN-1){1'b0}}, rs1_i < rs2_i};
      default: begin
        // Result stays zero
        illegal = 1'b1;
      end
    endcase
  end

  // Pack the result record
  assign res_data.result        = res;
  assign res_data.rob_idx       = rob_idx_i;
  assign res_data.except_raised = illegal;
  assign res_data.except_code   = E_ILLEGAL_INSTRUCTION;

  // Output register, its ready is the issue ready
  spill_cell_flush #(
    .DATA_T(cdb_data_t)
  ) u_out_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .valid_i(valid_i),
    .ready_o(ready_o),
    .data_i (res_data),
    .valid_o(valid_o),
    .ready_i(ready_i),
    .data_o (data_o)
  );

endmodule

/* hw/exec_cluster_top.sv */
// ----------------------------------------
// Integer execution cluster top level
// ALU and multiplier units merged onto one CDB by the arbiter
// ----------------------------------------

module exec_cluster_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // ALU issue port
  input  logic                             alu_valid_i,
  output logic                             alu_ready_o,
  input  logic [exec_pkg::EU_CTL_LEN-1:0]  alu_ctl_i,
  input  exec_pkg::rob_idx_t               alu_rob_idx_i,
  input  logic [exec_pkg::XLEN-1:0]        alu_rs1_i,
  input  logic [exec_pkg::XLEN-1:0]        alu_rs2_i,
  // Multiplier issue port
  input  logic                             mult_valid_i,
  output logic                             mult_ready_o,
  input  logic [exec_pkg::EU_CTL_LEN-1:0]  mult_ctl_i,
  input  exec_pkg::rob_idx_t               mult_rob_idx_i,
  input  logic [exec_pkg::XLEN-1:0]        mult_rs1_i,
  input  logic [exec_pkg::XLEN-1:0]        mult_rs2_i,
  // Common data bus
  output logic                             cdb_valid_o,
  input  logic                             cdb_ready_i,
  output logic [exec_pkg::XLEN-1:0]        cdb_result_o,
  output exec_pkg::rob_idx_t               cdb_rob_idx_o,
  output logic                             cdb_except_raised_o,
  output exec_pkg::except_code_t           cdb_except_code_o
);

  import exec_pkg::*;

  // Unit to arbiter links
  logic      alu_out_valid, alu_out_ready;
  logic      mult_out_valid, mult_out_ready;
  cdb_data_t alu_out_data, mult_out_data;

  alu_unit u_alu (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
    .valid_i(alu_valid_i), .ready_o(alu_ready_o), .ctl_i(alu_ctl_i),
    .rob_idx_i(alu_rob_idx_i), .rs1_i(alu_rs1_i), .rs2_i(alu_rs2_i),
    .valid_o(alu_out_valid), .ready_i(alu_out_ready), .data_o(alu_out_data)
  );

  mult_unit u_mult (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
    .valid_i(mult_valid_i), .ready_o(mult_ready_o), .ctl_i(mult_ctl_i),
    .rob_idx_i(mult_rob_idx_i), .rs1_i(mult_rs1_i), .rs2_i(mult_rs2_i),
    .valid_o(mult_out_valid), .ready_i(mult_out_ready), .data_o(mult_out_data)
  );

  result_arbiter u_arb (
    .clk_i(clk_i), .rst_ni(rst_ni), .flush_i(flush_i),
    .alu_valid_i(alu_out_valid), .alu_ready_o(alu_out_ready),
    .alu_data_i(alu_out_data),
    .mult_valid_i(mult_out_valid), .mult_ready_o(mult_out_ready),
    .mult_data_i(mult_out_data),
    .cdb_valid_o(cdb_valid_o), .cdb_ready_i(cdb_ready_i),
    .cdb_result_o(cdb_result_o), .cdb_rob_idx_o(cdb_rob_idx_o),
    .cdb_except_raised_o(cdb_except_raised_o),
    .cdb_except_code_o(cdb_except_code_o)
  );

endmodule

/* hw/exec_pkg.sv */
// ----------------------------------------
// Shared definitions of the integer execution cluster
// Word width, ROB index, operation codes and the CDB result record
// Imported by the units, the arbiter and the top level
// ----------------------------------------

package exec_pkg;

  // Datapath width
  localparam int unsigned XLEN = 32;

  // Reorder buffer index
  localparam int unsigned ROB_IDX_LEN = 4;
  typedef logic [ROB_IDX_LEN-1:0] rob_idx_t;

  // Exception codes
  typedef logic [3:0] except_code_t;
  localparam except_code_t E_ILLEGAL_INSTRUCTION = 4'd2;

  // Width of the unit control code
  localparam int unsigned EU_CTL_LEN = 4;

  // ALU control codes
  localparam logic [EU_CTL_LEN-1:0] ALU_ADD  = 4'd0;
  localparam logic [EU_CTL_LEN-1:0] ALU_SUB  = 4'd1;
  localparam logic [EU_CTL_LEN-1:0] ALU_AND  = 4'd2;
  localparam logic [EU_CTL_LEN-1:0] ALU_OR   = 4'd3;
  localparam logic [EU_CTL_LEN-1:0] ALU_XOR  = 4'd4;
  localparam logic [EU_CTL_LEN-1:0] ALU_SLL  = 4'd5;
  localparam logic [EU_CTL_LEN-1:0] ALU_SRL  = 4'd6;
  localparam logic [EU_CTL_LEN-1:0] ALU_SRA  = 4'd7;
  localparam logic [EU_CTL_LEN-1:0] ALU_SLT  = 4'd8;
  localparam logic [EU_CTL_LEN-1:0] ALU_SLTU = 4'd9;

  // Multiplier control codes
  localparam logic [EU_CTL_LEN-1:0] MULT_MUL    = 4'd0;
  localparam logic [EU_CTL_LEN-1:0] MULT_MULH   = 4'd1;
  localparam logic [EU_CTL_LEN-1:0] MULT_MULHU  = 4'd2;
  localparam logic [EU_CTL_LEN-1:0] MULT_MULHSU = 4'd3;

  // Multiplier stages, stage 0 included
  localparam int unsigned MULT_DEPTH = 3;

  // Result record carried on the common data bus
  typedef struct packed {
    logic [XLEN-1:0] result;
    rob_idx_t        rob_idx;
    logic            except_raised;
    except_code_t    except_code;
  } cdb_data_t;

endpackage

/* hw/mult_unit.sv */
// ----------------------------------------
// Pipelined integer multiplier execution unit
// MUL, MULH, MULHU, MULHSU over MULT_DEPTH stages plus spill cell
// MULH-type ops cache operands and low product for a following MUL
// ----------------------------------------

module mult_unit (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             flush_i,
  // Issue port
  input  logic                             valid_i,
  output logic                             ready_o,
  input  logic [exec_pkg::EU_CTL_LEN-1:0]  ctl_i,
  input  exec_pkg::rob_idx_t               rob_idx_i,
  input  logic [exec_pkg::XLEN-1:0]        rs1_i,
  input  logic [exec_pkg::XLEN-1:0]        rs2_i,
  // Result port towards the arbiter
  output logic                             valid_o,
  input  logic                             ready_i,
  output exec_pkg::cdb_data_t              data_o
);

  import exec_pkg::*;

  localparam int unsigned LAST = MULT_DEPTH - 1;

  // Stage 0 decode and product
  logic                   sign_a, sign_b, is_mulh, illegal;
  logic [XLEN:0]          op_a, op_b;
  logic signed [2*XLEN+1:0] prod_full;
  logic [2*XLEN-1:0]      prod;
  logic                   cache_hit, cache_load;
  cdb_data_t              s0_data;

  // Operand cache
  logic                   cache_vld_q;
  logic [XLEN-1:0]        cache_rs1_q, cache_rs2_q, cache_low_q;

  // Registered stages 1 to LAST
  logic [LAST:1]          stg_valid_q;
  cdb_data_t              stg_data_q [LAST:1];
  logic                   advance, cell_ready;

  // ---------------------------------------
  // Stage 0
  // ---------------------------------------
  always_comb begin
    sign_a  = 1'b0;
    sign_b  = 1'b0;
    is_mulh = 1'b0;
    illegal = 1'b0;
    case (ctl_i)
      MULT_MUL: begin
        // Low half does not depend on signedness
      end
      MULT_MULH: begin
        sign_a  = 1'b1;
        sign_b  = 1'b1;
        is_mulh = 1'b1;
      end
      MULT_MULHU:  is_mulh = 1'b1;
      MULT_MULHSU: begin
        sign_a  = 1'b1;
        is_mulh = 1'b1;
      end
      default: illegal = 1'b1;
    endcase
  end

  // 33-bit operands whose top bit picks signed or unsigned
  assign op_a      = {sign_a & rs1_i[XLEN-1], rs1_i};
  assign op_b      = {sign_b & rs2_i[XLEN-1], rs2_i};
  assign prod_full = $signed(op_a) * $signed(op_b);
  assign prod      = prod_full[2*XLEN-1:0];

  // MUL on the exact cached operands reuses the stored low half
  assign cache_hit  = (ctl_i == MULT_MUL) && cache_vld_q &&
                      (rs1_i == cache_rs1_q) && (rs2_i == cache_rs2_q);
  assign cache_load = is_mulh & valid_i & advance & ~flush_i;

  assign s0_data.result        = illegal   ? '0 :
                                 is_mulh   ? prod[2*XLEN-1:XLEN] :
                                 cache_hit ? cache_low_q : prod[XLEN-1:0];
  assign s0_data.rob_idx       = rob_idx_i;
  assign s0_data.except_raised = illegal;
  assign s0_data.except_code   = E_ILLEGAL_INSTRUCTION;

  // Cache valid flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cache_vld_q <= 1'b0;
    end else if (cache_load) begin
      cache_vld_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cache_load) begin
      cache_rs1_q <= rs1_i;
      cache_rs2_q <= rs2_i;
      cache_low_q <= prod[XLEN-1:0];
    end
  end

  // ---------------------------------------
  // Stage registers and stall
  // ---------------------------------------
  // Move when the cell takes the last stage or the last stage is empty
  assign advance = cell_ready | ~stg_valid_q[LAST];
  assign ready_o = advance;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stg_valid_q <= '0;
    end else if (flush_i) begin
      stg_valid_q <= '0;
    end else if (advance) begin
      stg_valid_q[1] <= valid_i;
      for (int i = 2; i <= LAST; i++) begin
        stg_valid_q[i] <= stg_valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      stg_data_q[1] <= s0_data;
      for (int i = 2; i <= LAST; i++) begin
        stg_data_q[i] <= stg_data_q[i-1];
      end
    end
  end

  spill_cell_flush #(
    .DATA_T(cdb_data_t)
  ) u_out_reg (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .flush_i(flush_i),
    .valid_i(stg_valid_q[LAST]),
    .ready_o(cell_ready),
    .data_i (stg_data_q[LAST]),
    .valid_o(valid_o),
    .ready_i(ready_i),
    .data_o (data_o)
  );

  // Stalled last stage keeps its item
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    stg_valid_q[LAST] && !cell_ready && !flush_i |=>
      stg_valid_q[LAST] && $stable(stg_data_q[LAST]));

endmodule

/* hw/result_arbiter.sv */
// ----------------------------------------
// Round-robin merge of ALU and multiplier results onto the CDB
// Purely combinational path, one priority flop
// ----------------------------------------

module result_arbiter (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  // ALU result stream
  input  logic                        alu_valid_i,
  output logic                        alu_ready_o,
  input  exec_pkg::cdb_data_t         alu_data_i,
  // Multiplier result stream
  input  logic                        mult_valid_i,
  output logic                        mult_ready_o,
  input  exec_pkg::cdb_data_t         mult_data_i,
  // Common data bus
  output logic                        cdb_valid_o,
  input  logic                        cdb_ready_i,
  output logic [exec_pkg::XLEN-1:0]   cdb_result_o,
  output exec_pkg::rob_idx_t          cdb_rob_idx_o,
  output logic                        cdb_except_raised_o,
  output exec_pkg::except_code_t      cdb_except_code_o
);

  import exec_pkg::*;

  logic      prio_mult_q;
  logic      alu_gnt, mult_gnt;
  logic      xfer;
  cdb_data_t sel_data;

  // ---------------------------------------
  // Grant
  // ---------------------------------------
  // Contention goes to whoever did not win last time
  assign alu_gnt  = alu_valid_i & (~mult_valid_i | ~prio_mult_q);
  assign mult_gnt = mult_valid_i & (~alu_valid_i | prio_mult_q);

  // Flush blocks any transfer this cycle
  assign cdb_valid_o  = (alu_valid_i | mult_valid_i) & ~flush_i;
  assign xfer         = cdb_valid_o & cdb_ready_i;
  assign alu_ready_o  = alu_gnt & cdb_ready_i & ~flush_i;
  assign mult_ready_o = mult_gnt & cdb_ready_i & ~flush_i;

  // Priority flag, set means the multiplier is favoured
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_mult_q <= 1'b0;
    end else if (flush_i) begin
      prio_mult_q <= 1'b0;
    end else if (xfer) begin
      prio_mult_q <= alu_gnt;
    end
  end

  // ---------------------------------------
  // Data mux and split
  // ---------------------------------------
  assign sel_data            = mult_gnt ? mult_data_i : alu_data_i;
  assign cdb_result_o        = sel_data.result;
  assign cdb_rob_idx_o       = sel_data.rob_idx;
  assign cdb_except_raised_o = sel_data.except_raised;
  assign cdb_except_code_o   = sel_data.except_code;

  // One unit released per cycle at most
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(alu_ready_o && mult_ready_o));

endmodule

/* hw/spill_cell_flush.sv */
// ----------------------------------------
// Two-entry valid/ready output register with flush
// Main plus spill entry, ready_o comes straight from a flop
// DATA_T selects the payload type
// ----------------------------------------

module spill_cell_flush #(
  parameter type DATA_T = logic [7:0]
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  flush_i,
  // Upstream side
  input  logic  valid_i,
  output logic  ready_o,
  input  DATA_T data_i,
  // Downstream side
  output logic  valid_o,
  input  logic  ready_i,
  output DATA_T data_o
);

  logic  main_valid_q, spill_valid_q;
  DATA_T main_data_q, spill_data_q;
  logic  in_hs;

  // Ready only depends on spill occupancy, so no path from ready_i
  assign ready_o = ~spill_valid_q;
  // Flush cycle accepts nothing
  assign in_hs   = valid_i & ready_o & ~flush_i;

  // ---------------------------------------
  // Occupancy and payload
  // ---------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
    end else if (flush_i) begin
      main_valid_q  <= 1'b0;
      spill_valid_q <= 1'b0;
    end else if (!main_valid_q || ready_i) begin
      // Main entry free or draining
      if (spill_valid_q) begin
        main_valid_q  <= 1'b1;
        spill_valid_q <= 1'b0;
      end else begin
        main_valid_q <= in_hs;
      end
    end else if (in_hs) begin
      // Main stalled, park the new item
      spill_valid_q <= 1'b1;
    end
  end

  // Payload flops, qualified by the same conditions
  always_ff @(posedge clk_i) begin
    if (!main_valid_q || ready_i) begin
      main_data_q <= spill_valid_q ? spill_data_q : data_i;
    end else if (in_hs) begin
      spill_data_q <= data_i;
    end
  end

  assign valid_o = main_valid_q;
  assign data_o  = main_data_q;

  // Stalled output holds its payload
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i && !flush_i |=> $stable(data_o));

endmodule

/* verification/exec_cluster_tb.sv */
// ----------------------------------------
// Table-driven testbench of the execution cluster
// Issues ALU and multiplier ops, checks every CDB result
// against a scoreboard under random back-pressure and a flush
// ----------------------------------------

module exec_cluster_tb;

  import exec_pkg::*;

  localparam int TBL_MAX = 96;
  localparam int ROB_N   = 1 << ROB_IDX_LEN;
  // Illegal-instruction exception code
  localparam logic [3:0] EXC_ILLEGAL = 4'd2;

  logic clk = 1'b0;
  logic rst_n, flush;
  logic alu_valid, alu_ready, mult_valid, mult_ready;
  logic [EU_CTL_LEN-1:0] alu_ctl, mult_ctl;
  rob_idx_t alu_rob, mult_rob;
  logic [XLEN-1:0] alu_rs1, alu_rs2, mult_rs1, mult_rs2;
  logic cdb_valid, cdb_ready, cdb_exc;
  logic [XLEN-1:0] cdb_result;
  rob_idx_t cdb_rob;
  except_code_t cdb_code;

  // Stimulus table with expected result per entry
  logic            tbl_is_mult [0:TBL_MAX-1];
  logic [3:0]      tbl_ctl     [0:TBL_MAX-1];
  logic [31:0]     tbl_rs1     [0:TBL_MAX-1];
  logic [31:0]     tbl_rs2     [0:TBL_MAX-1];
  logic [31:0]     tbl_res     [0:TBL_MAX-1];
  logic            tbl_exc     [0:TBL_MAX-1];
  int              tbl_len = 0;
  int              n_built = 0;

  // Scoreboard indexed by ROB index
  logic            sb_pending [0:ROB_N-1];
  logic [31:0]     sb_res     [0:ROB_N-1];
  logic            sb_exc     [0:ROB_N-1];

  integer seed = 76;
  int     errors = 0;
  int     checks = 0;
  int     retired = 0;
  int     timeout_units;

  exec_cluster_top exec_cluster_top_inst (
    .clk_i(clk), .rst_ni(rst_n), .flush_i(flush),
    .alu_valid_i(alu_valid), .alu_ready_o(alu_ready), .alu_ctl_i(alu_ctl),
    .alu_rob_idx_i(alu_rob), .alu_rs1_i(alu_rs1), .alu_rs2_i(alu_rs2),
    .mult_valid_i(mult_valid), .mult_ready_o(mult_ready), .mult_ctl_i(mult_ctl),
    .mult_rob_idx_i(mult_rob), .mult_rs1_i(mult_rs1), .mult_rs2_i(mult_rs2),
    .cdb_valid_o(cdb_valid), .cdb_ready_i(cdb_ready), .cdb_result_o(cdb_result),
    .cdb_rob_idx_o(cdb_rob), .cdb_except_raised_o(cdb_exc), .cdb_except_code_o(cdb_code)
  );

  always #5 clk = ~clk;

  // CDB consumer ready about 70% of the cycles
  always @(posedge clk) begin
    #1;
    cdb_ready = ($unsigned($random(seed)) % 10) < 7;
  end

  // ----------------------------------------
  // Reference models
  // ----------------------------------------
  function automatic logic [31:0] alu_expect(input logic [3:0] ctl, input logic [31:0] a,
                                             input logic [31:0] b);
    logic [63:0] wide;
    logic [31:0] r;
    int          sh;
    sh   = int'(b[4:0]);
    r    = '0;
    wide = '0;
    case (ctl)
      ALU_ADD: r = a + b;
      ALU_SUB: r = a + ~b + 32'd1;
      ALU_AND: r = a & b;
      ALU_OR:  r = a | b;
      ALU_XOR: r = a ^ b;
      ALU_SLL: begin
        wide = {32'd0, a} << sh;
        r    = wide[31:0];
      end
      ALU_SRL: begin
        wide = {32'd0, a} >> sh;
        r    = wide[31:0];
      end
      // Sign-extend to 64 bits, then a plain right shift
      ALU_SRA: begin
        wide = {{32{a[31]}}, a} >> sh;
        r    = wide[31:0];
      end
      // Different signs decide alone
      ALU_SLT:  r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      ALU_SLTU: r = {31'd0, a < b};
      default:  r = '0;
    endcase
    return r;
  endfunction

  function automatic logic [31:0] mult_expect(input logic [3:0] ctl, input logic [31:0] a,
                                              input logic [31:0] b);
    logic [63:0] x, y, p;
    logic [31:0] r;
    // 64-bit modular product of the extended operands
    x = (ctl == MULT_MULH || ctl == MULT_MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
    y = (ctl == MULT_MULH) ? {{32{b[31]}}, b} : {32'd0, b};
    p = x * y;
    if (ctl > MULT_MULHSU) begin
      r = '0;
    end else if (ctl == MULT_MUL) begin
      r = p[31:0];
    end else begin
      r = p[63:32];
    end
    return r;
  endfunction

  // ----------------------------------------
  // Table construction
  // ----------------------------------------
  task automatic add_op(input logic is_mult, input logic [3:0] ctl, input logic [31:0] a,
                        input logic [31:0] b);
    tbl_is_mult[n_built] = is_mult;
    tbl_ctl[n_built]     = ctl;
    tbl_rs1[n_built]     = a;
    tbl_rs2[n_built]     = b;
    tbl_res[n_built]     = is_mult ? mult_expect(ctl, a, b) : alu_expect(ctl, a, b);
    tbl_exc[n_built]     = is_mult ? (ctl > 4'd3) : (ctl > 4'd9);
    n_built++;
  endtask

  task automatic build_table();
    logic [3:0] sh_ctl;
    // ALU and multiplier corner cases interleaved
    add_op(1'b0, ALU_ADD, 32'h7fff_ffff, 32'h0000_0001);
    add_op(1'b1, MULT_MUL, 32'hffff_ffff, 32'hffff_ffff);
    add_op(1'b0, ALU_SUB, 32'h0000_0000, 32'h0000_0001);
    add_op(1'b1, MULT_MULH, 32'hffff_ffff, 32'hffff_ffff);
    add_op(1'b0, ALU_AND, 32'hf0f0_f0f0, 32'hff00_ff00);
    add_op(1'b1, MULT_MULH, 32'h8000_0000, 32'h8000_0000);
    add_op(1'b0, ALU_OR, 32'hf0f0_f0f0, 32'hff00_ff00);
    add_op(1'b1, MULT_MULHU, 32'hffff_ffff, 32'hffff_ffff);
    add_op(1'b0, ALU_XOR, 32'hf0f0_f0f0, 32'hff00_ff00);
    add_op(1'b1, MULT_MULHSU, 32'h8000_0000, 32'hffff_ffff);
    add_op(1'b0, ALU_SLT, 32'hffff_ffff, 32'h0000_0001);
    add_op(1'b1, MULT_MULHSU, 32'hffff_ffff, 32'hffff_ffff);
    add_op(1'b0, ALU_SLT, 32'h0000_0001, 32'hffff_ffff);
    add_op(1'b1, MULT_MULH, 32'h8000_0000, 32'hffff_ffff);
    add_op(1'b0, ALU_SLT, 32'h8000_0000, 32'h7fff_ffff);
    // Cache check with MULH, then MUL on equal and on different operands
    add_op(1'b1, MULT_MULH, 32'h1234_5678, 32'h9abc_def0);
    add_op(1'b0, ALU_SLTU, 32'hffff_ffff, 32'h0000_0001);
    add_op(1'b1, MULT_MUL, 32'h1234_5678, 32'h9abc_def0);
    add_op(1'b0, ALU_SLTU, 32'h0000_0001, 32'hffff_ffff);
    add_op(1'b1, MULT_MUL, 32'h1234_5678, 32'h9abc_def1);
    add_op(1'b0, ALU_SRA, 32'h8000_0000, 32'h0000_001f);
    // Illegal codes on both units
    add_op(1'b1, 4'd4, 32'h0000_0003, 32'h0000_0005);
    add_op(1'b0, 4'd10, 32'h0000_0003, 32'h0000_0005);
    add_op(1'b1, 4'd15, 32'h0000_0007, 32'h0000_0009);
    add_op(1'b0, 4'd15, 32'h0000_0007, 32'h0000_0009);
    // Every shift amount with the upper rs2 bits set
    for (int sh = 0; sh < 32; sh++) begin
      case (sh % 3)
        0:       sh_ctl = ALU_SLL;
        1:       sh_ctl = ALU_SRL;
        default: sh_ctl = ALU_SRA;
      endcase
      add_op(1'b0, sh_ctl, 32'h8765_4321, 32'hffff_ffe0 | 32'(sh));
    end
    // Random legal ops alternating between units
    for (int k = 0; k < 24; k++) begin
      if (k % 2 == 0) begin
        add_op(1'b0, 4'($unsigned($random(seed)) % 10), $random(seed), $random(seed));
      end else begin
        add_op(1'b1, 4'($unsigned($random(seed)) % 4), $random(seed), $random(seed));
      end
    end
    tbl_len = n_built;
  endtask

  // ----------------------------------------
  // Issue side
  // ----------------------------------------
  function automatic rob_idx_t rob_of(input int pos);
    return rob_idx_t'(pos % ROB_N);
  endfunction

  // Arguments are table positions and -1 leaves a port idle
  task automatic issue_pair(input int ia, input int im);
    logic a_pend, m_pend;
    a_pend = (ia >= 0);
    m_pend = (im >= 0);
    // An index is reused only after its older result retired
    while ((a_pend && sb_pending[rob_of(ia)]) || (m_pend && sb_pending[rob_of(im)])) begin
      @(posedge clk);
      #1;
    end
    if (a_pend) begin
      alu_ctl = tbl_ctl[ia];
      alu_rob = rob_of(ia);
      alu_rs1 = tbl_rs1[ia];
      alu_rs2 = tbl_rs2[ia];
      sb_res[rob_of(ia)]     = tbl_res[ia];
      sb_exc[rob_of(ia)]     = tbl_exc[ia];
      sb_pending[rob_of(ia)] = 1'b1;
    end
    if (m_pend) begin
      mult_ctl = tbl_ctl[im];
      mult_rob = rob_of(im);
      mult_rs1 = tbl_rs1[im];
      mult_rs2 = tbl_rs2[im];
      sb_res[rob_of(im)]     = tbl_res[im];
      sb_exc[rob_of(im)]     = tbl_exc[im];
      sb_pending[rob_of(im)] = 1'b1;
    end
    alu_valid  = a_pend;
    mult_valid = m_pend;
    while (a_pend || m_pend) begin
      // Handshake sampled mid-cycle, where it is settled
      @(negedge clk);
      if (alu_valid && alu_ready) a_pend = 1'b0;
      if (mult_valid && mult_ready) m_pend = 1'b0;
      @(posedge clk);
      #1;
      alu_valid  = a_pend;
      mult_valid = m_pend;
    end
  endtask

  task automatic run_entries(input int first, input int last);
    int i;
    i = first;
    while (i < last) begin
      // Neighbours on different units share a slot
      if (i + 1 < last && tbl_is_mult[i] != tbl_is_mult[i+1]) begin
        if (tbl_is_mult[i]) issue_pair(i + 1, i);
        else issue_pair(i, i + 1);
        i += 2;
      end else begin
        if (tbl_is_mult[i]) issue_pair(-1, i);
        else issue_pair(i, -1);
        i++;
      end
    end
  endtask

  // ----------------------------------------
  // CDB monitor and drain
  // ----------------------------------------
  always @(negedge clk) begin
    if (rst_n && cdb_valid && cdb_ready) begin
      if (!sb_pending[cdb_rob]) begin
        errors++;
        $display("Unexpected or duplicated result for ROB index %0d at time %0t",
                 cdb_rob, $time);
      end else begin
        checks++;
        if (cdb_result !== sb_res[cdb_rob]) begin
          errors++;
          $display("Fail at %0t: ROB %0d result %08h, expected %08h", $time, cdb_rob,
                   cdb_result, sb_res[cdb_rob]);
        end
        if (cdb_exc !== sb_exc[cdb_rob]) begin
          errors++;
          $display("Fail at %0t: ROB %0d except_raised %b, expected %b", $time, cdb_rob,
                   cdb_exc, sb_exc[cdb_rob]);
        end
        if (sb_exc[cdb_rob] && cdb_code !== EXC_ILLEGAL) begin
          errors++;
          $display("Fail at %0t: ROB %0d except_code %0d, expected %0d", $time, cdb_rob,
                   cdb_code, EXC_ILLEGAL);
        end
        sb_pending[cdb_rob] = 1'b0;
        retired++;
      end
    end
  end

  function automatic logic any_pending();
    logic p;
    p = 1'b0;
    for (int k = 0; k < ROB_N; k++) p = p | sb_pending[k];
    return p;
  endfunction

  task automatic drain_and_check(input int expected_cnt);
    int wait_cycles;
    wait_cycles = 0;
    while (any_pending() && wait_cycles < 100) begin
      @(posedge clk);
      #1;
      wait_cycles++;
    end
    for (int k = 0; k < ROB_N; k++) begin
      if (sb_pending[k]) begin
        errors++;
        $display("Result for ROB index %0d never arrived", k);
      end
    end
    if (retired != expected_cnt) begin
      errors++;
      $display("Expected %0d results in the batch but %0d were retired", expected_cnt,
               retired);
    end
  endtask

  // ----------------------------------------
  // Watchdog
  // ----------------------------------------
  initial begin
    wait (tbl_len > 0);
    timeout_units = (tbl_len * (MULT_DEPTH + 4) * 4 + 200) * 10;
    #(timeout_units);
    $display("Timeout: the run did not finish within %0d time units", timeout_units);
    $display("Results checked: %0d, errors: %0d", checks, errors + 1);
    $display("Testbench failed");
    $finish;
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_n      = 1'b0;
    flush      = 1'b0;
    alu_valid  = 1'b0;
    mult_valid = 1'b0;
    alu_ctl    = '0;
    mult_ctl   = '0;
    alu_rob    = '0;
    mult_rob   = '0;
    alu_rs1    = '0;
    alu_rs2    = '0;
    mult_rs1   = '0;
    mult_rs2   = '0;
    cdb_ready  = 1'b0;
    for (int k = 0; k < ROB_N; k++) sb_pending[k] = 1'b0;
    build_table();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Full batch
    retired = 0;
    run_entries(0, tbl_len);
    drain_and_check(tbl_len);

    // Another batch ending on paired ops, flushed while both units hold results
    run_entries(0, tbl_len);
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    @(negedge clk);
    if (cdb_valid !== 1'b0) begin
      errors++;
      $display("Fail at %0t: cdb_valid_o high in the cycle after flush", $time);
    end
    for (int k = 0; k < ROB_N; k++) sb_pending[k] = 1'b0;
    @(posedge clk);
    #1;

    // Fresh batch after flush
    retired = 0;
    run_entries(0, tbl_len);
    drain_and_check(tbl_len);

    $display("Results checked: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
